// ==== hdl/board_pkg.sv ====
/*
  board supervisor package
  shared constants, exit word views and the report request type
*/
package board_pkg;

  // width of the heartbeat counter whose top bit drives the LED
  localparam int HEARTBEAT_W = 8;

  // clock cycles per UART bit
  localparam int BAUD_DIV = 4;
  localparam int BAUD_CNT_W = $clog2(BAUD_DIV);

  // header plus four data bytes
  localparam int REPORT_BYTES = 5;
  localparam int REPORT_IDX_W = $clog2(REPORT_BYTES);

  localparam logic [7:0] HDR_PASS = 8'hE0;
  localparam logic [7:0] HDR_FAIL = 8'hEF;

  // the exit word is read as raw bytes for the UART and as code plus result bit
  typedef struct packed {
    logic [30:0] code;
    logic        fail; // board result flag in bit 0
  } exit_fields_s;

  typedef union packed {
    logic [31:0]  raw;
    exit_fields_s fields;
  } exit_word_u;

  // request from the sequencer to the reporter
  typedef struct packed {
    logic       valid;
    exit_word_u word;
  } report_req_s;

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    RUN    = 2'd1,
    REPORT = 2'd2,
    DONE   = 2'd3
  } seq_state_e;

endpackage

// ==== hdl/board_supervisor_top.sv ====
/*
  board supervisor top
  heartbeat, run sequencing and UART exit report for the core wrapper
*/
`timescale 1ns/1ns

module board_supervisor_top (
  input  logic                  clk_gen,
  input  logic                  rst_ni,
  input  logic                  fetch_enable_i,
  input  logic                  exit_valid_i,
  input  board_pkg::exit_word_u exit_word_i,
  output logic                  core_fetch_o,
  output logic                  uart_tx_o,
  output logic                  exit_valid_o,
  output logic                  exit_value_o,
  output logic                  heartbeat_led_o,
  output logic                  rst_led_o
);

  logic                   bit_tick;
  board_pkg::report_req_s report_req;
  logic                   report_ready;
  logic                   report_done;
  logic [7:0]             tx_byte;
  logic                   tx_byte_valid;
  logic                   tx_byte_ready;
  logic                   tx_idle;

  assign rst_led_o = rst_ni; // LED shows reset state

  heartbeat_timer u_heartbeat_timer (
    .clk_gen         (clk_gen),
    .rst_ni          (rst_ni),
    .heartbeat_led_o (heartbeat_led_o),
    .bit_tick_o      (bit_tick)
  );

  run_sequencer u_run_sequencer (
    .clk_gen        (clk_gen),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .exit_valid_i   (exit_valid_i),
    .exit_value_i   (exit_word_i),
    .report_ready_i (report_ready),
    .report_done_i  (report_done),
    .core_fetch_o   (core_fetch_o),
    .report_o       (report_req),
    .exit_valid_o   (exit_valid_o),
    .exit_value_o   (exit_value_o)
  );

  exit_reporter u_exit_reporter (
    .clk_gen        (clk_gen),
    .rst_ni         (rst_ni),
    .report_i       (report_req),
    .report_ready_o (report_ready),
    .byte_o         (tx_byte),
    .byte_valid_o   (tx_byte_valid),
    .byte_ready_i   (tx_byte_ready),
    .tx_idle_i      (tx_idle),
    .done_o         (report_done)
  );

  uart_tx u_uart_tx (
    .clk_gen      (clk_gen),
    .rst_ni       (rst_ni),
    .bit_tick_i   (bit_tick),
    .byte_i       (tx_byte),
    .byte_valid_i (tx_byte_valid),
    .byte_ready_o (tx_byte_ready),
    .idle_o       (tx_idle),
    .tx_o         (uart_tx_o)
  );

endmodule

// ==== hdl/exit_reporter.sv ====
/*
  exit reporter
  sends a pass/fail header and the four exit word bytes to the UART
*/
`timescale 1ns/1ns

module exit_reporter (
  input  logic                   clk_gen,
  input  logic                   rst_ni,
  input  board_pkg::report_req_s report_i,
  output logic                   report_ready_o,
  output logic [7:0]             byte_o,
  output logic                   byte_valid_o,
  input  logic                   byte_ready_i,
  input  logic                   tx_idle_i,
  output logic                   done_o
);

  logic                               busy_q;
  logic                               drain_q; // last byte handed over
  logic [board_pkg::REPORT_IDX_W-1:0] idx_q;
  board_pkg::exit_word_u              word_q;

  always_ff @(posedge clk_gen or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      drain_q <= 1'b0;
      idx_q   <= '0;
      done_o  <= 1'b0;
    end else begin
      done_o <= busy_q && drain_q && tx_idle_i; // one cycle pulse as busy clears
      if (report_i.valid && report_ready_o) begin
        busy_q  <= 1'b1;
        drain_q <= 1'b0;
        idx_q   <= '0;
      end else if (byte_valid_o && byte_ready_i) begin
        if (idx_q == board_pkg::REPORT_IDX_W'(board_pkg::REPORT_BYTES - 1)) begin
          drain_q <= 1'b1;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end else if (drain_q && tx_idle_i) begin
        busy_q  <= 1'b0; // stop bit of the last frame is out
        drain_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_gen) begin
    if (report_i.valid && report_ready_o) begin
      word_q <= report_i.word;
    end
  end

  always_comb begin
    case (idx_q)
      3'd0:    byte_o = word_q.fields.fail ? board_pkg::HDR_FAIL : board_pkg::HDR_PASS;
      3'd1:    byte_o = word_q.raw[7:0]; // lsb first
      3'd2:    byte_o = word_q.raw[15:8];
      3'd3:    byte_o = word_q.raw[23:16];
      default: byte_o = word_q.raw[31:24];
    endcase
  end

  assign report_ready_o = !busy_q;
  assign byte_valid_o   = busy_q && !drain_q;

  a_byte_hold : assert property (@(posedge clk_gen) disable iff (!rst_ni)
    byte_valid_o && !byte_ready_i |=> byte_valid_o && $stable(byte_o));

endmodule

// ==== hdl/heartbeat_timer.sv ====
/*
  heartbeat timer
  free-running LED counter and the UART bit tick divider
*/
`timescale 1ns/1ns

module heartbeat_timer (
  input  logic clk_gen,
  input  logic rst_ni,
  output logic heartbeat_led_o,
  output logic bit_tick_o
);

  logic [board_pkg::HEARTBEAT_W-1:0] count_q;
  logic [board_pkg::BAUD_CNT_W-1:0]  baud_q;

  always_ff @(posedge clk_gen or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
      baud_q  <= '0;
    end else begin
      count_q <= count_q + 1'b1; // wraps freely
      if (bit_tick_o) begin
        baud_q <= '0;
      end else begin
        baud_q <= baud_q + 1'b1;
      end
    end
  end

  assign heartbeat_led_o = count_q[board_pkg::HEARTBEAT_W-1];
  assign bit_tick_o      = (baud_q == board_pkg::BAUD_CNT_W'(board_pkg::BAUD_DIV - 1));

  // the divider must never produce back-to-back ticks
  a_tick_single : assert property (@(posedge clk_gen) disable iff (!rst_ni)
    bit_tick_o |=> !bit_tick_o);

endmodule

// ==== hdl/run_sequencer.sv ====
/*
  run sequencer
  releases the core on the board switch, captures the exit word,
  requests one report and then raises the board exit pins
*/
`timescale 1ns/1ns

module run_sequencer (
  input  logic                    clk_gen,
  input  logic                    rst_ni,
  input  logic                    fetch_enable_i,
  input  logic                    exit_valid_i,
  input  board_pkg::exit_word_u   exit_value_i,
  input  logic                    report_ready_i,
  input  logic                    report_done_i,
  output logic                    core_fetch_o,
  output board_pkg::report_req_s  report_o,
  output logic                    exit_valid_o,
  output logic                    exit_value_o
);

  board_pkg::seq_state_e state_q, state_d;
  board_pkg::exit_word_u word_q;
  logic                  req_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      board_pkg::IDLE: begin
        if (fetch_enable_i) state_d = board_pkg::RUN; // switch releases the core
      end
      board_pkg::RUN: begin
        if (exit_valid_i) state_d = board_pkg::REPORT;
      end
      board_pkg::REPORT: begin
        if (report_done_i) state_d = board_pkg::DONE;
      end
      default: state_d = state_q; // DONE holds until reset
    endcase
  end

  always_ff @(posedge clk_gen or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= board_pkg::IDLE;
      req_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == board_pkg::RUN && exit_valid_i) begin
        req_q <= 1'b1; // one report per run
      end else if (req_q && report_ready_i) begin
        req_q <= 1'b0;
      end
    end
  end

  // exit word capture
  always_ff @(posedge clk_gen) begin
    if (state_q == board_pkg::RUN && exit_valid_i) begin
      word_q <= exit_value_i;
    end
  end

  assign core_fetch_o   = (state_q == board_pkg::RUN);
  assign report_o.valid = req_q;
  assign report_o.word  = word_q;
  assign exit_valid_o   = (state_q == board_pkg::DONE);
  assign exit_value_o   = (state_q == board_pkg::DONE) & word_q.fields.fail;

  a_req_in_report : assert property (@(posedge clk_gen) disable iff (!rst_ni)
    report_o.valid |-> state_q == board_pkg::REPORT);

  // exit pins are sticky until the next reset
  a_exit_sticky : assert property (@(posedge clk_gen) disable iff (!rst_ni)
    exit_valid_o |=> exit_valid_o);

endmodule

// ==== hdl/uart_tx.sv ====
/*
  UART transmitter
  8N1 serializer, one bit per tick, ready only while the line is idle
*/
`timescale 1ns/1ns

module uart_tx (
  input  logic       clk_gen,
  input  logic       rst_ni,
  input  logic       bit_tick_i,
  input  logic [7:0] byte_i,
  input  logic       byte_valid_i,
  output logic       byte_ready_o,
  output logic       idle_o,
  output logic       tx_o
);

  logic [9:0] shift_q; // stop, data msb..lsb, start
  logic [3:0] ticks_q; // ticks left in the frame
  logic       tx_q;

  // ten ticks put the bits on the line, the eleventh closes the stop bit
  always_ff @(posedge clk_gen or negedge rst_ni) begin
    if (!rst_ni) begin
      ticks_q <= '0;
      tx_q    <= 1'b1; // line idles high
    end else begin
      if (byte_valid_i && byte_ready_o) begin
        ticks_q <= 4'd11;
      end else if (!idle_o && bit_tick_i) begin
        ticks_q <= ticks_q - 1'b1;
        tx_q    <= shift_q[0];
      end
    end
  end

  always_ff @(posedge clk_gen) begin
    if (byte_valid_i && byte_ready_o) begin
      shift_q <= {1'b1, byte_i, 1'b0};
    end else if (!idle_o && bit_tick_i) begin
      shift_q <= {1'b1, shift_q[9:1]}; // fill with stop level
    end
  end

  assign idle_o       = (ticks_q == 4'd0);
  assign byte_ready_o = idle_o;
  assign tx_o         = tx_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the board supervisor testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --timing -f sim.f --top-module tb_board_supervisor \
  -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/Vtb_board_supervisor > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see $SIM_LOG"
  exit 1
fi

if grep -q "TEST PASSED" "$SIM_LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $SIM_LOG"
  exit 1
fi

// ==== sim.f ====
hdl/board_pkg.sv
hdl/heartbeat_timer.sv
hdl/uart_tx.sv
hdl/exit_reporter.sv
hdl/run_sequencer.sv
hdl/board_supervisor_top.sv
tb/tb_board_supervisor.sv

// ==== tb/tb_board_supervisor.sv ====
/*
  board supervisor testbench
  reset, heartbeat, fetch gating and UART exit report checks
*/
`timescale 1ns/1ns

module tb_board_supervisor;

  localparam int CLK_PERIOD   = 4;
  localparam int LED_HALF     = 1 << (board_pkg::HEARTBEAT_W - 1); // cycles per LED level
  localparam int REPORT_LIMIT = board_pkg::REPORT_BYTES * 12 * board_pkg::BAUD_DIV + 40;
  localparam int TEST_COUNT   = 8;
  localparam int WATCHDOG_NS  = TEST_COUNT * 300 * CLK_PERIOD + 2400;

  logic                  clk_gen = 1'b0;
  logic                  rst_ni;
  logic                  fetch_enable_i;
  logic                  exit_valid_i;
  board_pkg::exit_word_u exit_word_i;
  logic                  core_fetch_o;
  logic                  uart_tx_o;
  logic                  exit_valid_o;
  logic                  exit_value_o;
  logic                  heartbeat_led_o;
  logic                  rst_led_o;

  logic       armed;    // first reset has reached the flops
  logic       captured; // exit word taken while the core ran
  int         run_cycles;
  int         rx_count;
  logic [7:0] exp_bytes [board_pkg::REPORT_BYTES];
  logic       exp_fail;
  logic [31:0] rng_state;
  int         error_count;
  int         tests_passed;
  int         tests_failed;
  int         test_num;

  board_supervisor_top UUT (
    .clk_gen         (clk_gen),
    .rst_ni          (rst_ni),
    .fetch_enable_i  (fetch_enable_i),
    .exit_valid_i    (exit_valid_i),
    .exit_word_i     (exit_word_i),
    .core_fetch_o    (core_fetch_o),
    .uart_tx_o       (uart_tx_o),
    .exit_valid_o    (exit_valid_o),
    .exit_value_o    (exit_value_o),
    .heartbeat_led_o (heartbeat_led_o),
    .rst_led_o       (rst_led_o)
  );

  always #(CLK_PERIOD / 2) clk_gen = ~clk_gen;

  always_ff @(posedge clk_gen or negedge rst_ni) begin
    if (!rst_ni) begin
      run_cycles <= 0;
      captured   <= 1'b0;
    end else begin
      run_cycles <= run_cycles + 1;
      if (core_fetch_o && exit_valid_i) begin
        captured <= 1'b1;
      end
    end
  end

  task automatic log_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  task automatic log_failure(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  a_reset_values : assert property (@(posedge clk_gen)
    armed && (!rst_ni || $rose(rst_ni)) |->
      !core_fetch_o && !exit_valid_o && !exit_value_o && !heartbeat_led_o && uart_tx_o)
    else log_mismatch("outputs not at their reset values");

  a_rst_led : assert property (@(posedge clk_gen) disable iff (!armed) rst_led_o == rst_ni)
    else log_mismatch("rst_led_o does not follow rst_ni");

  a_heartbeat : assert property (@(posedge clk_gen) disable iff (!rst_ni || !armed)
    heartbeat_led_o == ((run_cycles / LED_HALF) % 2 == 1))
    else log_mismatch($sformatf("heartbeat LED wrong after %0d cycles", run_cycles));

  a_fetch_release : assert property (@(posedge clk_gen) disable iff (!rst_ni || !armed)
    fetch_enable_i && UUT.u_run_sequencer.state_q == board_pkg::IDLE |=> core_fetch_o)
    else log_mismatch("core_fetch_o did not rise after fetch enable");

  a_fetch_stopped : assert property (@(posedge clk_gen) disable iff (!rst_ni || !armed)
    captured |-> !core_fetch_o)
    else log_mismatch("core_fetch_o high after the exit word was captured");

  a_exit_after_report : assert property (@(posedge clk_gen) disable iff (!rst_ni || !armed)
    $rose(exit_valid_o) |-> rx_count == board_pkg::REPORT_BYTES && exit_value_o == exp_fail)
    else log_mismatch($sformatf("exit pins rose after %0d bytes, value %b", rx_count,
                                exit_value_o));

  a_exit_hold : assert property (@(posedge clk_gen) disable iff (!rst_ni || !armed)
    exit_valid_o |=> exit_valid_o && $stable(exit_value_o))
    else log_mismatch("exit pins changed before reset");

  // mid-bit sampler for the 8N1 line
  always begin : uart_decoder
    logic [7:0] data;
    @(negedge uart_tx_o);
    repeat (board_pkg::BAUD_DIV / 2) @(negedge clk_gen);
    assert (!uart_tx_o) else log_mismatch("start bit not low at mid-bit");
    for (int i = 0; i < 8; i++) begin
      repeat (board_pkg::BAUD_DIV) @(negedge clk_gen);
      data[i] = uart_tx_o; // lsb first
    end
    repeat (board_pkg::BAUD_DIV) @(negedge clk_gen);
    assert (uart_tx_o) else log_mismatch("stop bit not high");
    assert (rx_count < board_pkg::REPORT_BYTES && data == exp_bytes[rx_count])
      else log_mismatch($sformatf("byte %0d got %02h", rx_count, data));
    rx_count++;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_gen);
  endtask

  task automatic apply_reset();
    @(negedge clk_gen);
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    exit_valid_i   = 1'b0;
    exit_word_i    = '0;
    rx_count       = 0;
    @(negedge clk_gen);
    armed = 1'b1;
    wait_cycles(4);
    rst_ni = 1'b1;
  endtask

  task automatic pulse_exit(input logic [31:0] word);
    @(negedge clk_gen);
    exit_word_i.raw = word;
    exit_valid_i    = 1'b1;
    @(negedge clk_gen);
    exit_valid_i = 1'b0;
  endtask

  // header from bit 0, then the word lsb byte first
  task automatic expect_report(input logic [31:0] word);
    exp_fail     = word[0];
    exp_bytes[0] = word[0] ? board_pkg::HDR_FAIL : board_pkg::HDR_PASS;
    for (int i = 1; i < board_pkg::REPORT_BYTES; i++) begin
      exp_bytes[i] = word[8*(i-1) +: 8];
    end
  endtask

  task automatic wait_exit_valid();
    int waited;
    waited = 0;
    while (!exit_valid_o && waited < REPORT_LIMIT) begin
      @(negedge clk_gen);
      waited++;
    end
    assert (exit_valid_o)
      else log_failure($sformatf("exit_valid_o did not rise within %0d cycles", REPORT_LIMIT));
  endtask

  task automatic run_report(input logic [31:0] word);
    expect_report(word);
    @(negedge clk_gen);
    fetch_enable_i = 1'b1;
    pulse_exit(word);
    wait_exit_valid();
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_num++;
    if (error_count == errors_before) begin
      tests_passed++;
      $display("test %0d %s: ok", test_num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", test_num, name, error_count - errors_before);
    end
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("run did not finish within %0d ns, stopped by the watchdog", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    int          errors_before;
    int          toggles;
    logic        led_prev;
    logic [31:0] word;
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    exit_valid_i   = 1'b0;
    exit_word_i    = '0;
    armed          = 1'b0;
    rx_count       = 0;
    exp_fail       = 1'b0;
    rng_state      = 32'd20;
    error_count    = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    test_num       = 0;
    expect_report(32'h0);

    errors_before = error_count;
    apply_reset();
    wait_cycles(4);
    assert (!core_fetch_o && !exit_valid_o && !exit_value_o && uart_tx_o && rst_led_o)
      else log_mismatch("outputs left reset values with no stimulus");
    finish_test("reset values", errors_before);

    errors_before = error_count;
    apply_reset();
    toggles  = 0;
    led_prev = heartbeat_led_o;
    repeat (2 * LED_HALF + 8) begin
      @(negedge clk_gen);
      if (heartbeat_led_o != led_prev) toggles++;
      led_prev = heartbeat_led_o;
    end
    assert (toggles == 2)
      else log_mismatch($sformatf("heartbeat toggled %0d times, expected 2", toggles));
    finish_test("heartbeat", errors_before);

    errors_before = error_count;
    apply_reset();
    rng_state = xorshift32(rng_state);
    pulse_exit(rng_state); // core not released yet
    wait_cycles(60);
    assert (rx_count == 0 && !exit_valid_o && !core_fetch_o)
      else log_mismatch("exit pulse in idle was not ignored");
    @(negedge clk_gen);
    fetch_enable_i = 1'b1;
    @(negedge clk_gen);
    assert (core_fetch_o) else log_mismatch("core_fetch_o low one edge after fetch enable");
    finish_test("fetch gating", errors_before);

    for (int n = 0; n < 4; n++) begin
      errors_before = error_count;
      rng_state = xorshift32(rng_state);
      word      = {rng_state[31:1], n[0]}; // alternate pass and fail
      apply_reset();
      run_report(word);
      wait_cycles(20);
      assert (rx_count == board_pkg::REPORT_BYTES && exit_valid_o && exit_value_o == word[0])
        else log_mismatch($sformatf("report of %08h incomplete or exit value wrong", word));
      finish_test($sformatf("exit word %08h", word), errors_before);
    end

    errors_before = error_count;
    rng_state = xorshift32(rng_state);
    word      = rng_state;
    apply_reset();
    expect_report(word);
    @(negedge clk_gen);
    fetch_enable_i = 1'b1;
    pulse_exit(word);
    wait_cycles(60);
    pulse_exit(~word); // lands in the middle of the report
    wait_exit_valid();
    pulse_exit(~word);
    wait_cycles(60);
    assert (rx_count == board_pkg::REPORT_BYTES && exit_valid_o && exit_value_o == word[0])
      else log_mismatch("repeated exit pulse changed the report or the exit pins");
    finish_test("repeated exit pulse", errors_before);

    $display("%0d tests: %0d ok, %0d with errors, %0d check errors", test_num, tests_passed,
             tests_failed, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
